// File: dv/l1_dcache_props.sv
/*
  Bus and handshake checks for the data cache, bound to its top level.
  Each failure raises $error and bumps a counter that the testbench watches.
*/
`timescale 1ns/1ps

module l1_dcache_props (
  input logic                    clk,
  input logic                    reset,
  input logic                    req,
  input logic                    done,
  input logic                    busy,
  input logic                    bus_reqcyc,
  input logic                    bus_reqack,
  input l1_dcache_pkg::word_t    bus_req,
  input l1_dcache_pkg::bus_tag_t bus_reqtag,
  input logic                    bus_respcyc,
  input logic                    bus_respack
);

  int unsigned prop_failures = 0;

  // quiet outputs right after any reset cycle
  reset_quiet: assert property (@(posedge clk)
    !reset |=> !busy && !done && !bus_reqcyc && !bus_respack)
    else begin prop_failures++; $error("outputs active after reset"); end

  // beat held until acked
  req_hold: assert property (@(posedge clk) disable iff (!reset)
    bus_reqcyc && !bus_reqack |=> bus_reqcyc && $stable(bus_req) && $stable(bus_reqtag))
    else begin prop_failures++; $error("request beat changed before ack"); end

  // done is a single pulse, only with req
  done_pulse: assert property (@(posedge clk) disable iff (!reset)
    done |=> !done)
    else begin prop_failures++; $error("done longer than one cycle"); end

  done_with_req: assert property (@(posedge clk) disable iff (!reset)
    done |-> req && busy)
    else begin prop_failures++; $error("done without req or busy"); end

  // ack only follows a presented beat
  respack_cause: assert property (@(posedge clk) disable iff (!reset)
    $rose(bus_respack) |-> $past(bus_respcyc))
    else begin prop_failures++; $error("respack rose without respcyc"); end

endmodule

bind l1_dcache l1_dcache_props u_props (
  .clk        (clk),
  .reset      (reset),
  .req        (req),
  .done       (done),
  .busy       (busy),
  .bus_reqcyc (bus_reqcyc),
  .bus_reqack (bus_reqack),
  .bus_req    (bus_req),
  .bus_reqtag (bus_reqtag),
  .bus_respcyc(bus_respcyc),
  .bus_respack(bus_respack)
);

// File: dv/l1_dcache_tb.sv
/*
  Testbench for the data cache: memory model with random bus delays, golden
  byte memory, load/store stimulus from an LFSR, immediate checks and timeout.
*/
`timescale 1ns/1ps

module l1_dcache_tb;
  import l1_dcache_pkg::*;

  // accesses per test, used for the cycle limit
  localparam int N_TYPES  = 7;
  localparam int N_MERGE  = 19;
  localparam int N_EVICT  = 10;
  localparam int N_RANDOM = 40;
  localparam int LIMIT    = 40 * (N_TYPES + N_MERGE + N_EVICT + N_RANDOM) + 200;

  logic     clk;
  logic     reset;
  logic     req;
  logic     write;
  addr_t    addr;
  word_t    wdata;
  mem_op_e  op;
  word_t    rdata;
  logic     done;
  logic     busy;
  logic     bus_reqcyc;
  logic     bus_reqack;
  word_t    bus_req;
  bus_tag_t bus_reqtag;
  logic     bus_respcyc;
  logic     bus_respack;
  word_t    bus_resp;
  bus_tag_t bus_resptag;

  word_t       mem_words [addr_t];
  logic [7:0]  gold [addr_t];
  addr_t       wb_bases [$];
  logic [31:0] lfsr = 32'hc0ea03e0;
  int          cycle_cnt = 0;
  logic        reqcyc_seen = 1'b0;

  l1_dcache #(.WAYS(4)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run stopped");
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (bus_reqcyc) reqcyc_seen = 1'b1;
    if (cycle_cnt > LIMIT) stop_with_fail($sformatf("timeout after %0d cycles", LIMIT));
  end

  // stop at the first property failure
  always @(negedge clk) begin
    if (UUT.u_props.prop_failures != 0) stop_with_fail("a bus or handshake property failed");
  end

  // galois lfsr, one step per bit taken
  function automatic word_t rand_bits(input int n);
    word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic int op_size(input mem_op_e o);
    case (o)
      OP_LD, OP_SD:        return 8;
      OP_LW, OP_LWU, OP_SW: return 4;
      OP_LH, OP_LHU, OP_SH: return 2;
      default:             return 1;
    endcase
  endfunction

  function automatic addr_t line_base(input int t, input int s);
    return {tag_t'(t), index_t'(s), 6'd0};
  endfunction

  // natural alignment for the access size
  function automatic addr_t aligned_offset(input mem_op_e o);
    return addr_t'(rand_bits(6)) & ~addr_t'(op_size(o) - 1);
  endfunction

  // expected load from the golden bytes, little endian, then extension
  function automatic word_t expect_load(input mem_op_e o, input addr_t a);
    word_t v;
    int    n;
    n = op_size(o);
    v = '0;
    for (int b = n - 1; b >= 0; b--) v = {v[55:0], gold[a + b]};
    if ((o inside {OP_LW, OP_LH, OP_LB}) && v[8 * n - 1]) begin
      for (int b = n; b < 8; b++) v[8 * b +: 8] = 8'hff;
    end
    return v;
  endfunction

  task automatic preload_line(input addr_t base);
    word_t w;
    for (int i = 0; i < BEATS; i++) begin
      w = rand_bits(64);
      mem_words[base + 8 * i] = w;
      for (int b = 0; b < 8; b++) gold[base + 8 * i + b] = w[8 * b +: 8];
    end
  endtask

  // one cpu access; req held until done, then dropped for a cycle
  task automatic access(input mem_op_e o, input addr_t a, input word_t d, output int cycles);
    word_t exp;
    @(negedge clk);
    req    = 1'b1;
    write  = o inside {OP_SD, OP_SW, OP_SH, OP_SB};
    addr   = a;
    wdata  = d;
    op     = o;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!done);
    if (write) begin
      for (int b = 0; b < op_size(o); b++) gold[a + b] = d[8 * b +: 8];
    end else begin
      exp = expect_load(o, a);
      assert (rdata === exp) else stop_with_fail($sformatf(
        "[FAIL] t=%0t %s at %h got %h expected %h", $time, o.name(), a, rdata, exp));
    end
    @(negedge clk);
    req   = 1'b0;
    write = 1'b0;
  endtask

  // memory side: ack one request beat after 0 to 3 cycles
  task automatic take_beat(output word_t data, output bus_tag_t tag);
    data = bus_req;
    tag  = bus_reqtag;
    repeat (int'(rand_bits(2))) @(negedge clk);
    bus_reqack = 1'b1;
    @(negedge clk);
    bus_reqack = 1'b0;
  endtask

  task automatic send_line(input addr_t base);
    for (int i = 0; i < BEATS; i++) begin
      repeat (int'(rand_bits(2))) @(negedge clk);
      if (!mem_words.exists(base + 8 * i)) begin
        stop_with_fail($sformatf("memory read of unloaded address %h", base + 8 * i));
      end
      bus_resp    = mem_words[base + 8 * i];
      bus_resptag = TAG_READ;
      bus_respcyc = 1'b1;
      do @(negedge clk); while (!bus_respack);
      bus_respcyc = 1'b0;
    end
  endtask

  initial begin : memory_model
    word_t    a_beat;
    word_t    d_beat;
    bus_tag_t t_beat;
    bus_reqack  = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp    = '0;
    bus_resptag = '0;
    forever begin
      @(negedge clk);
      if (reset && bus_reqcyc) begin
        take_beat(a_beat, t_beat);
        assert (a_beat[5:0] == 6'd0) else stop_with_fail($sformatf("[FAIL] t=%0t unaligned %h",
          $time, a_beat));
        if (t_beat == TAG_WRITE) begin
          wb_bases.push_back(addr_t'(a_beat));
          for (int i = 0; i < BEATS; i++) begin
            if (!bus_reqcyc) stop_with_fail("writeback burst ended before eight data beats");
            take_beat(d_beat, t_beat);
            assert (t_beat == TAG_WRITE) else stop_with_fail($sformatf("[FAIL] t=%0t data tag %h",
              $time, t_beat));
            mem_words[addr_t'(a_beat) + 8 * i] = d_beat;
          end
        end else begin
          assert (t_beat == TAG_READ) else stop_with_fail($sformatf("[FAIL] t=%0t read tag %h",
            $time, t_beat));
          send_line(addr_t'(a_beat));
        end
      end
    end
  end

  initial begin : stimulus
    addr_t   a;
    addr_t   ev [5];
    mem_op_e o;
    mem_op_e loads [7];
    mem_op_e stores [4];
    int      cycles;
    logic    known;
    req   = 1'b0;
    write = 1'b0;
    addr  = '0;
    wdata = '0;
    op    = OP_LD;
    reset = 1'b0;
    repeat (10) @(negedge clk);
    reset = 1'b1;
    repeat (2) @(negedge clk);

    // every load type, each on a fresh line
    loads = '{OP_LD, OP_LW, OP_LH, OP_LB, OP_LWU, OP_LHU, OP_LBU};
    for (int i = 0; i < N_TYPES; i++) begin
      preload_line(line_base(3, i + 1));
      access(loads[i], line_base(3, i + 1) + aligned_offset(loads[i]), '0, cycles);
    end

    // store merge of each width, neighbours read back too
    a = line_base(5, 10) + 16;
    preload_line(line_base(5, 10));
    stores = '{OP_SD, OP_SW, OP_SH, OP_SB};
    for (int i = 0; i < 4; i++) begin
      access(stores[i], a + 8 - op_size(stores[i]), rand_bits(64), cycles);
      access(OP_LD, a, '0, cycles);
      access(OP_LD, a - 8, '0, cycles);
      access(OP_LD, a + 8, '0, cycles);
    end
    access(OP_LB, a + 7, '0, cycles);
    access(OP_LBU, a + 7, '0, cycles);
    reqcyc_seen = 1'b0;
    access(OP_LW, a + 4, '0, cycles);
    assert (cycles == 2) else stop_with_fail($sformatf("[FAIL] t=%0t hit took %0d cycles",
      $time, cycles));
    assert (!reqcyc_seen) else stop_with_fail($sformatf("[FAIL] t=%0t bus request during a hit",
      $time));

    // five tags in one set, four ways, so dirty lines get evicted
    wb_bases.delete();
    for (int i = 0; i < 5; i++) begin
      ev[i] = line_base(8 + i, 20);
      preload_line(ev[i]);
    end
    for (int i = 0; i < 5; i++) access(OP_SD, ev[i] + 8 * i, rand_bits(64), cycles);
    for (int i = 0; i < 5; i++) access(OP_LD, ev[i] + 8 * i, '0, cycles);
    assert (wb_bases.size() != 0) else stop_with_fail($sformatf(
      "[FAIL] t=%0t no writeback burst for five tags in one set", $time));
    foreach (wb_bases[j]) begin
      known = 1'b0;
      for (int i = 0; i < 5; i++) known |= (wb_bases[j] == ev[i]);
      assert (known) else stop_with_fail($sformatf("[FAIL] t=%0t writeback to stray line %h",
        $time, wb_bases[j]));
    end

    // random mix over a few sets and tags
    for (int s = 24; s < 28; s++) begin
      for (int t = 0; t < 6; t++) preload_line(line_base(16 + t, s));
    end
    for (int i = 0; i < N_RANDOM; i++) begin
      o = mem_op_e'(4'(rand_bits(4) % 11));
      a = line_base(16 + int'(rand_bits(3) % 6), 24 + int'(rand_bits(2)));
      access(o, a + aligned_offset(o), rand_bits(64), cycles);
    end

    repeat (4) @(negedge clk);
    if (UUT.u_props.prop_failures == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      stop_with_fail("a bus or handshake property failed");
    end
  end

endmodule

// File: hdl/bus_engine.sv
/*
  Bus side of the cache. Sends address and writeback beats with cyc/ack,
  acknowledges response beats and assembles eight of them into a fill line.
*/
`timescale 1ns/1ps

module bus_engine (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    bus_reqack,
  input  logic                    bus_respcyc,
  input  l1_dcache_pkg::word_t    bus_resp,
  input  l1_dcache_pkg::bus_tag_t bus_resptag,
  output logic                    bus_reqcyc,
  output l1_dcache_pkg::word_t    bus_req,
  output l1_dcache_pkg::bus_tag_t bus_reqtag,
  output logic                    bus_respack,
  mem_cmd_if.engine               cmd
);
  import l1_dcache_pkg::*;

  logic [3:0] beat_cnt;
  logic       wb_active;
  logic       fill_active;
  logic       req_accept;
  logic       wb_next;
  logic       resp_take;
  logic       resp_fill;
  line_t      wb_buf;
  line_t      fill_buf;

  // beat on the request side accepted this edge
  assign req_accept = bus_reqcyc && bus_reqack;
  // more writeback data still to send
  assign wb_next    = req_accept && wb_active && (beat_cnt != 4'(BEATS));

  // capture only once per beat, the ack cycle is skipped
  assign resp_take  = bus_respcyc && !bus_respack;
  assign resp_fill  = resp_take && fill_active && (bus_resptag == TAG_READ);

  assign cmd.fill_line = fill_buf;

  // handshake and beat counting
  always_ff @(posedge clk) begin
    if (!reset) begin
      bus_reqcyc    <= 1'b0;
      bus_respack   <= 1'b0;
      wb_active     <= 1'b0;
      fill_active   <= 1'b0;
      beat_cnt      <= '0;
      cmd.wb_done   <= 1'b0;
      cmd.fill_done <= 1'b0;
    end else begin
      cmd.wb_done   <= 1'b0;
      cmd.fill_done <= 1'b0;
      // every response beat is acked, stray tags too
      bus_respack   <= resp_take;

      if (cmd.wb_start) begin
        bus_reqcyc <= 1'b1;
        wb_active  <= 1'b1;
        beat_cnt   <= '0;
      end else if (cmd.fill_start) begin
        bus_reqcyc  <= 1'b1;
        fill_active <= 1'b1;
        beat_cnt    <= '0;
      end else if (wb_next) begin
        beat_cnt <= beat_cnt + 4'd1;
      end else if (req_accept) begin
        // last beat of the burst, or the single read address beat
        bus_reqcyc <= 1'b0;
        if (wb_active) begin
          wb_active   <= 1'b0;
          cmd.wb_done <= 1'b1;
        end
      end

      if (resp_fill) begin
        beat_cnt <= beat_cnt + 4'd1;
        if (beat_cnt == 4'(BEATS - 1)) begin
          fill_active   <= 1'b0;
          cmd.fill_done <= 1'b1;
        end
      end
    end
  end

  // beat payload and line buffers
  always_ff @(posedge clk) begin
    if (cmd.wb_start) begin
      bus_req    <= word_t'(cmd.wb_addr);
      bus_reqtag <= TAG_WRITE;
      wb_buf     <= cmd.wb_line;
    end else if (cmd.fill_start) begin
      bus_req    <= word_t'(cmd.fill_addr);
      bus_reqtag <= TAG_READ;
    end else if (wb_next) begin
      // word 0 goes out first
      bus_req <= wb_buf[63:0];
      wb_buf  <= wb_buf >> 64;
    end

    // shift in from the top so word 0 lands in the low bits
    if (resp_fill) begin
      fill_buf <= {bus_resp, fill_buf[511:64]};
    end
  end

endmodule

// File: hdl/cache_ctrl.sv
/*
  Request sequencer of the data cache. Accepts one CPU access at a time and
  steps through lookup, optional writeback, fill, install and response.
*/
`timescale 1ns/1ps

module cache_ctrl #(
  parameter int WAYS = 4
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req,
  input  logic                    write,
  input  l1_dcache_pkg::addr_t    addr,
  input  l1_dcache_pkg::mem_op_e  op,
  input  logic                    hit,
  input  logic [$clog2(WAYS)-1:0] hit_way,
  input  logic [$clog2(WAYS)-1:0] victim_way,
  input  logic                    victim_dirty,
  input  l1_dcache_pkg::tag_t     victim_tag,
  input  l1_dcache_pkg::line_t    victim_line,
  output l1_dcache_pkg::index_t   lookup_index,
  output logic                    install_en,
  output logic [$clog2(WAYS)-1:0] install_way,
  output l1_dcache_pkg::tag_t     install_tag,
  output logic                    install_dirty,
  output logic                    store_en,
  output logic [$clog2(WAYS)-1:0] store_way,
  output l1_dcache_pkg::offset_t  store_offset,
  output logic                    done,
  output logic                    busy,
  mem_cmd_if.ctrl                 cmd
);
  import l1_dcache_pkg::*;

  localparam int WAY_W = $clog2(WAYS);

  ctrl_state_e      state;
  ctrl_state_e      state_nxt;
  addr_t            addr_q;
  logic             store_q;
  logic [WAY_W-1:0] way_q;
  logic             miss_dirty;
  logic             miss_clean;

  // latched address split into tag, index and offset
  assign {install_tag, lookup_index, store_offset} = addr_q;

  assign miss_dirty = (state == S_LOOKUP) && !hit && victim_dirty;
  assign miss_clean = (state == S_LOOKUP) && !hit && !victim_dirty;

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE:      if (req) state_nxt = S_LOOKUP;
      S_LOOKUP: begin
        if (hit) begin
          state_nxt = S_RESPOND;
        end else if (victim_dirty) begin
          state_nxt = S_WRITEBACK;
        end else begin
          state_nxt = S_FILL;
        end
      end
      S_WRITEBACK: if (cmd.wb_done) state_nxt = S_FILL;
      S_FILL:      if (cmd.fill_done) state_nxt = S_INSTALL;
      S_INSTALL:   state_nxt = S_RESPOND;
      // req is ignored here, back to idle regardless
      S_RESPOND:   state_nxt = S_IDLE;
      default:     state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // request capture at acceptance, way choice once the lookup is valid
  always_ff @(posedge clk) begin
    if (state == S_IDLE && req) begin
      addr_q  <= addr;
      store_q <= write && (op inside {OP_SD, OP_SW, OP_SH, OP_SB});
    end
    if (state == S_LOOKUP) begin
      way_q <= hit ? hit_way : victim_way;
    end
  end

  // fill lands clean in the chosen way
  assign install_en    = (state == S_INSTALL);
  assign install_way   = way_q;
  assign install_dirty = 1'b0;

  // store merge happens during respond, on hit and miss alike
  assign store_en  = (state == S_RESPOND) && store_q;
  assign store_way = way_q;

  assign done = (state == S_RESPOND);
  assign busy = (state != S_IDLE);

  // writeback of the victim line straight from the arrays
  assign cmd.wb_start = miss_dirty;
  assign cmd.wb_addr  = {victim_tag, lookup_index, offset_t'(0)};
  assign cmd.wb_line  = victim_line;

  // fill right after lookup, or once the writeback drains
  assign cmd.fill_start = miss_clean || ((state == S_WRITEBACK) && cmd.wb_done);
  assign cmd.fill_addr  = {install_tag, lookup_index, offset_t'(0)};

endmodule

// File: hdl/l1_dcache.sv
/*
  Top level of the write-back data cache.
  CPU ports go to the controller, bus ports to the bus engine.
*/
`timescale 1ns/1ps

module l1_dcache #(
  parameter int WAYS = 4
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req,
  input  logic                    write,
  input  l1_dcache_pkg::addr_t    addr,
  input  l1_dcache_pkg::word_t    wdata,
  input  l1_dcache_pkg::mem_op_e  op,
  output l1_dcache_pkg::word_t    rdata,
  output logic                    done,
  output logic                    busy,
  output logic                    bus_reqcyc,
  input  logic                    bus_reqack,
  output l1_dcache_pkg::word_t    bus_req,
  output l1_dcache_pkg::bus_tag_t bus_reqtag,
  input  logic                    bus_respcyc,
  output logic                    bus_respack,
  input  l1_dcache_pkg::word_t    bus_resp,
  input  l1_dcache_pkg::bus_tag_t bus_resptag
);
  import l1_dcache_pkg::*;

  localparam int WAY_W = $clog2(WAYS);

  index_t           lookup_index;
  tag_t             install_tag;
  tag_t             victim_tag;
  offset_t          store_offset;
  line_t            victim_line;
  logic             hit;
  logic             victim_dirty;
  logic             install_en;
  logic             install_dirty;
  logic             store_en;
  logic [WAY_W-1:0] hit_way;
  logic [WAY_W-1:0] victim_way;
  logic [WAY_W-1:0] install_way;
  logic [WAY_W-1:0] store_way;

  mem_cmd_if cmd_if ();

  cache_ctrl #(.WAYS(WAYS)) u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .write        (write),
    .addr         (addr),
    .op           (op),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_line  (victim_line),
    .lookup_index (lookup_index),
    .install_en   (install_en),
    .install_way  (install_way),
    .install_tag  (install_tag),
    .install_dirty(install_dirty),
    .store_en     (store_en),
    .store_way    (store_way),
    .store_offset (store_offset),
    .done         (done),
    .busy         (busy),
    .cmd          (cmd_if)
  );

  // lookup compares against the latched request tag, same as the install tag
  tag_store #(.WAYS(WAYS)) u_tags (
    .clk          (clk),
    .reset        (reset),
    .lookup_index (lookup_index),
    .lookup_tag   (install_tag),
    .install_en   (install_en),
    .install_way  (install_way),
    .install_tag  (install_tag),
    .install_dirty(install_dirty),
    .store_en     (store_en),
    .store_way    (store_way),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  line_store #(.WAYS(WAYS)) u_lines (
    .clk          (clk),
    .lookup_index (lookup_index),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .install_en   (install_en),
    .install_way  (install_way),
    .fill_line    (cmd_if.fill_line),
    .store_en     (store_en),
    .store_way    (store_way),
    .store_offset (store_offset),
    .op           (op),
    .wdata        (wdata),
    .victim_line  (victim_line),
    .rdata        (rdata)
  );

  bus_engine u_engine (
    .clk          (clk),
    .reset        (reset),
    .bus_reqack   (bus_reqack),
    .bus_respcyc  (bus_respcyc),
    .bus_resp     (bus_resp),
    .bus_resptag  (bus_resptag),
    .bus_reqcyc   (bus_reqcyc),
    .bus_req      (bus_req),
    .bus_reqtag   (bus_reqtag),
    .bus_respack  (bus_respack),
    .cmd          (cmd_if)
  );

endmodule

// File: hdl/l1_dcache_pkg.sv
/*
  Shared types and constants for the set-associative data cache.
  Modules import this in their bodies and use scoped names in port lists.
*/
package l1_dcache_pkg;

  // byte address and its split into tag, set index and line offset
  typedef logic [31:0] addr_t;
  typedef logic [20:0] tag_t;
  typedef logic [4:0]  index_t;
  typedef logic [5:0]  offset_t;

  // one bus word, and a full line with word 0 in the low bits
  typedef logic [63:0]  word_t;
  typedef logic [511:0] line_t;

  // data beats per line transfer
  localparam int BEATS = 8;

  // bus tags on request and response beats
  typedef logic [1:0] bus_tag_t;
  localparam bus_tag_t TAG_READ  = 2'b01;
  localparam bus_tag_t TAG_WRITE = 2'b10;

  // load and store operations
  typedef enum logic [3:0] {
    OP_LD,
    OP_LW,
    OP_LH,
    OP_LB,
    OP_LWU,
    OP_LHU,
    OP_LBU,
    OP_SD,
    OP_SW,
    OP_SH,
    OP_SB
  } mem_op_e;

  // controller sequence
  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_WRITEBACK,
    S_FILL,
    S_INSTALL,
    S_RESPOND
  } ctrl_state_e;

endpackage

// File: hdl/line_store.sv
/*
  Line data array of the cache.
  Extracts load data with sign or zero extension, merges stores and installs fills.
*/
`timescale 1ns/1ps

module line_store #(
  parameter int WAYS = 4
) (
  input  logic                     clk,
  input  l1_dcache_pkg::index_t    lookup_index,
  input  logic [$clog2(WAYS)-1:0]  hit_way,
  input  logic [$clog2(WAYS)-1:0]  victim_way,
  input  logic                     install_en,
  input  logic [$clog2(WAYS)-1:0]  install_way,
  input  l1_dcache_pkg::line_t     fill_line,
  input  logic                     store_en,
  input  logic [$clog2(WAYS)-1:0]  store_way,
  input  l1_dcache_pkg::offset_t   store_offset,
  input  l1_dcache_pkg::mem_op_e   op,
  input  l1_dcache_pkg::word_t     wdata,
  output l1_dcache_pkg::line_t     victim_line,
  output l1_dcache_pkg::word_t     rdata
);
  import l1_dcache_pkg::*;

  localparam int SETS = 1 << $bits(index_t);

  line_t      line_mem [WAYS][SETS];
  line_t      hit_line;
  line_t      store_line;
  line_t      merged_line;
  word_t      hit_word;
  word_t      shifted;
  word_t      store_word;
  word_t      size_mask;
  logic [8:0] word_base;
  logic [5:0] bit_shift;

  // word position in the line, byte position in the word
  assign word_base = {store_offset[5:3], 6'd0};
  assign bit_shift = {store_offset[2:0], 3'd0};

  assign victim_line = line_mem[victim_way][lookup_index];

  // load path
  assign hit_line = line_mem[hit_way][lookup_index];
  assign hit_word = hit_line[word_base +: 64];
  assign shifted  = hit_word >> bit_shift;

  always_comb begin
    case (op)
      OP_LD:   rdata = shifted;
      OP_LW:   rdata = {{32{shifted[31]}}, shifted[31:0]};
      OP_LH:   rdata = {{48{shifted[15]}}, shifted[15:0]};
      OP_LB:   rdata = {{56{shifted[7]}}, shifted[7:0]};
      OP_LWU:  rdata = {32'd0, shifted[31:0]};
      OP_LHU:  rdata = {48'd0, shifted[15:0]};
      OP_LBU:  rdata = {56'd0, shifted[7:0]};
      // stores return nothing
      default: rdata = '0;
    endcase
  end

  // bytes touched by the store, before shifting into place
  always_comb begin
    case (op)
      OP_SD:   size_mask = '1;
      OP_SW:   size_mask = 64'h0000_0000_ffff_ffff;
      OP_SH:   size_mask = 64'h0000_0000_0000_ffff;
      OP_SB:   size_mask = 64'h0000_0000_0000_00ff;
      default: size_mask = '0;
    endcase
  end

  // store path
  assign store_line = line_mem[store_way][lookup_index];
  assign store_word = store_line[word_base +: 64];

  always_comb begin
    merged_line = store_line;
    merged_line[word_base +: 64] = (store_word & ~(size_mask << bit_shift)) |
                                   ((wdata & size_mask) << bit_shift);
  end

  // install and store never overlap in one cycle
  always_ff @(posedge clk) begin
    if (install_en) begin
      line_mem[install_way][lookup_index] <= fill_line;
    end else if (store_en) begin
      line_mem[store_way][lookup_index] <= merged_line;
    end
  end

endmodule

// File: hdl/mem_cmd_if.sv
/*
  Command link between the cache controller and the bus engine.
  The controller starts writebacks and fills, the engine reports completion.
*/
`timescale 1ns/1ps

interface mem_cmd_if;
  import l1_dcache_pkg::*;

  // writeback of a dirty victim
  logic  wb_start;
  addr_t wb_addr;
  line_t wb_line;
  logic  wb_done;

  // line fill for a miss
  logic  fill_start;
  addr_t fill_addr;
  logic  fill_done;
  line_t fill_line;

  modport ctrl (
    output wb_start, wb_addr, wb_line, fill_start, fill_addr,
    input  wb_done, fill_done
  );

  modport engine (
    input  wb_start, wb_addr, wb_line, fill_start, fill_addr,
    output wb_done, fill_done, fill_line
  );

endinterface

// File: hdl/tag_store.sv
/*
  Tag, valid and dirty state for every way and set.
  Compares all ways at the registered index and picks a victim way.
*/
`timescale 1ns/1ps

module tag_store #(
  parameter int WAYS = 4
) (
  input  logic                    clk,
  input  logic                    reset,
  input  l1_dcache_pkg::index_t   lookup_index,
  input  l1_dcache_pkg::tag_t     lookup_tag,
  input  logic                    install_en,
  input  logic [$clog2(WAYS)-1:0] install_way,
  input  l1_dcache_pkg::tag_t     install_tag,
  input  logic                    install_dirty,
  input  logic                    store_en,
  input  logic [$clog2(WAYS)-1:0] store_way,
  output logic                    hit,
  output logic [$clog2(WAYS)-1:0] hit_way,
  output logic [$clog2(WAYS)-1:0] victim_way,
  output logic                    victim_dirty,
  output l1_dcache_pkg::tag_t     victim_tag
);
  import l1_dcache_pkg::*;

  localparam int WAY_W = $clog2(WAYS);
  localparam int SETS  = 1 << $bits(index_t);

  tag_t                      tag_mem [WAYS][SETS];
  logic [WAYS-1:0][SETS-1:0] valid_bits;
  logic [WAYS-1:0][SETS-1:0] dirty_bits;
  logic [WAYS-1:0]           match;
  logic [7:0]                lfsr;

  // parallel tag compare across ways
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      match[w] = valid_bits[w][lookup_index] && (tag_mem[w][lookup_index] == lookup_tag);
    end
  end

  // one-hot match to way number
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (match[w]) begin
        hit_way = WAY_W'(w);
      end
    end
  end

  assign hit = |match;

  // hit way on a hit, otherwise the pseudo-random pointer
  assign victim_way   = hit ? hit_way : lfsr[WAY_W-1:0];
  assign victim_dirty = valid_bits[victim_way][lookup_index] &&
                        dirty_bits[victim_way][lookup_index];
  assign victim_tag   = tag_mem[victim_way][lookup_index];

  // galois lfsr, steps every cycle
  always_ff @(posedge clk) begin
    if (!reset) begin
      lfsr <= 8'h01;
    end else begin
      lfsr <= {1'b0, lfsr[7:1]} ^ (lfsr[0] ? 8'hb8 : 8'h00);
    end
  end

  // valid and dirty bits
  always_ff @(posedge clk) begin
    if (!reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (install_en) begin
        valid_bits[install_way][lookup_index] <= 1'b1;
        dirty_bits[install_way][lookup_index] <= install_dirty;
      end
      // store marks the line modified
      if (store_en) begin
        dirty_bits[store_way][lookup_index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (install_en) begin
      tag_mem[install_way][lookup_index] <= install_tag;
    end
  end

endmodule

// File: l1_dcache.f
hdl/l1_dcache_pkg.sv
hdl/mem_cmd_if.sv
hdl/tag_store.sv
hdl/line_store.sv
hdl/bus_engine.sv
hdl/cache_ctrl.sv
hdl/l1_dcache.sv
dv/l1_dcache_props.sv
dv/l1_dcache_tb.sv
